//--- nabp_frontend.f
nabp_pkg.sv
nabp_config_regs.sv
sinogram_addresser.sv
sinogram_ram.sv
projection_line_fetcher.sv
line_buffer.sv
nabp_frontend.sv
tb_clock_gen.sv
tb_nabp_frontend.sv

//--- Makefile
# Verilator build and run for the sinogram front end

VERILATOR ?= verilator
TOP ?= tb_nabp_frontend
FILELIST ?= nabp_frontend.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
EXTRA_FLAGS ?=

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_nabp_frontend.sv
module tb_nabp_frontend;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int line_size = nabp_pkg::default_line_size;
    localparam int sample_w = nabp_pkg::default_sample_w;
    localparam int buf_depth = nabp_pkg::default_buf_depth;
    localparam int s_w = $clog2(line_size);
    localparam int depth = nabp_pkg::half_turn * line_size;
    localparam int sg_addr_w = $clog2(depth);
    localparam int n_entries = 6;

    // angle step, pop chance in percent and number of angles k*step below 180
    localparam int step_tab [n_entries] = '{45, 60, 1, 90, 179, 7};
    localparam int density_tab [n_entries] = '{50, 20, 100, 35, 100, 60};
    localparam int angles_tab [n_entries] = '{4, 3, 180, 2, 2, 26};

    logic                            clk;
    logic                            reset_n;
    logic                            reg_wr;
    logic                            reg_rd;
    logic [nabp_pkg::reg_addr_w-1:0] reg_addr;
    logic [nabp_pkg::reg_data_w-1:0] reg_wdata;
    logic [nabp_pkg::reg_data_w-1:0] reg_rdata;
    logic                            sg_wr_en;
    logic [sg_addr_w-1:0]            sg_wr_addr;
    logic [sample_w-1:0]             sg_wr_data;
    logic                            out_valid;
    logic [sample_w-1:0]             out_sample;
    logic [nabp_pkg::angle_w-1:0]    out_angle;
    logic [s_w-1:0]                  out_s;
    logic                            out_pop;

    // reference copy of the sinogram memory
    logic [sample_w-1:0] model [depth];
    logic [31:0]         rng_state;
    int                  error_count;
    int                  check_count;
    int                  cycle_count;

    tb_clock_gen #(.period_ns(4), .reset_cycles(10)) clock_gen_i (
        .clk     (clk),
        .reset_n (reset_n)
    );

    nabp_frontend #(
        .line_size (line_size),
        .sample_w  (sample_w),
        .buf_depth (buf_depth)
    ) dut_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .sg_wr_en   (sg_wr_en),
        .sg_wr_addr (sg_wr_addr),
        .sg_wr_data (sg_wr_data),
        .out_valid  (out_valid),
        .out_sample (out_sample),
        .out_angle  (out_angle),
        .out_s      (out_s),
        .out_pop    (out_pop)
    );

    // xorshift32 on the shared state
    function automatic logic [31:0] draw_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("%s", what);
    endtask

    // bus tasks start and end on a falling edge
    task automatic write_reg(input logic [nabp_pkg::reg_addr_w-1:0] addr,
                             input logic [nabp_pkg::reg_data_w-1:0] data);
        reg_wr = 1'b1;
        reg_addr = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [nabp_pkg::reg_addr_w-1:0] addr,
                            output logic [nabp_pkg::reg_data_w-1:0] data);
        reg_rd = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        data = reg_rdata;
    endtask

    task automatic load_sinogram();
        logic [31:0] r;
        sg_wr_en = 1'b1;
        for (int a = 0; a < depth; a++)
        begin
            r = draw_random();
            model[a] = r[sample_w-1:0];
            sg_wr_addr = sg_addr_w'(a);
            sg_wr_data = r[sample_w-1:0];
            @(negedge clk);
        end
        sg_wr_en = 1'b0;
    endtask

    task automatic run_entry(input int idx);
        int                            step;
        int                            density;
        int                            n_angles;
        int                            total;
        int                            received;
        int                            k;
        int                            s;
        logic [nabp_pkg::reg_data_w-1:0] rd;
        logic                          seen_busy;
        logic                          busy_fell;
        logic                          extra_seen;

        step = step_tab[idx];
        density = density_tab[idx];
        n_angles = angles_tab[idx];
        total = n_angles * line_size;
        $display("entry %0d: step %0d, %0d angles, pop chance %0d", idx, step, n_angles, density);

        write_reg(nabp_pkg::reg_step, 16'(step));
        read_reg(nabp_pkg::reg_step, rd);
        check_value("reg_step", 32'(rd), 32'(step));

        write_reg(nabp_pkg::reg_ctrl, 16'h0001);
        // count clears one cycle after the registered kick
        @(negedge clk);
        read_reg(nabp_pkg::reg_count, rd);
        check_value("reg_count after kick", 32'(rd), 32'd0);
        read_reg(nabp_pkg::reg_status, rd);
        check_value("reg_status after kick", 32'(rd), 32'h1);

        received = 0;
        seen_busy = 1'b0;
        busy_fell = 1'b0;
        reg_rd = 1'b1;
        reg_addr = nabp_pkg::reg_status;
        while (!busy_fell || (received < total))
        begin
            @(negedge clk);
            if (reg_rdata[0])
            begin
                seen_busy = 1'b1;
                check_value("reg_status done bit while busy", 32'(reg_rdata[1]), 32'd0);
            end
            else if (seen_busy)
                busy_fell = 1'b1;
            out_pop = 1'b0;
            if (out_valid && ((draw_random() % 32'd100) < 32'(density)))
            begin
                if (received >= total)
                    report_failure("an output sample appeared after the last expected one");
                else
                begin
                    // angle index major and position minor
                    k = received / line_size;
                    s = received % line_size;
                    check_value("out_angle", 32'(out_angle), 32'(k * step));
                    check_value("out_s", 32'(out_s), 32'(s));
                    check_value("out_sample", 32'(out_sample),
                                32'(model[k * line_size + s]));
                    received++;
                end
                out_pop = 1'b1;
            end
        end
        // let the last pop take effect
        @(negedge clk);
        out_pop = 1'b0;
        reg_rd = 1'b0;

        extra_seen = 1'b0;
        repeat (2 * line_size)
        begin
            @(negedge clk);
            if (out_valid && !extra_seen)
            begin
                extra_seen = 1'b1;
                report_failure("the line buffer still holds data after the run ended");
            end
        end

        read_reg(nabp_pkg::reg_count, rd);
        check_value("reg_count", 32'(rd), 32'(n_angles));
        read_reg(nabp_pkg::reg_status, rd);
        check_value("reg_status", 32'(rd), 32'h2);
    endtask

    initial
    begin
        logic [nabp_pkg::reg_data_w-1:0] rd;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        sg_wr_en = 1'b0;
        sg_wr_addr = '0;
        sg_wr_data = '0;
        out_pop = 1'b0;
        rng_state = 32'd39;
        error_count = 0;
        check_count = 0;

        @(negedge clk);
        while (reset_n)
            @(negedge clk);
        check_value("out_valid after reset", 32'(out_valid), 32'd0);
        read_reg(nabp_pkg::reg_status, rd);
        check_value("reg_status after reset", 32'(rd), 32'd0);

        load_sinogram();
        for (int i = 0; i < n_entries; i++)
            run_entry(i);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // limit scales with the total number of samples
    initial
    begin
        int limit;
        limit = 500;
        for (int i = 0; i < n_entries; i++)
            limit += angles_tab[i] * line_size * 4;
        cycle_count = 0;
        while (cycle_count < limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen
#(
    parameter int period_ns = 4,
    parameter int reset_cycles = 10
)
(
    output logic clk,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever
            #(period_ns / 2) clk = ~clk;
    end

    // reset_n is active high here
    initial
    begin
        reset_n = 1'b1;
        repeat (reset_cycles)
            @(posedge clk);
        @(negedge clk);
        reset_n = 1'b0;
    end

endmodule

//--- nabp_frontend.sv
module nabp_frontend
#(
    parameter int line_size = nabp_pkg::default_line_size,
    parameter int sample_w = nabp_pkg::default_sample_w,
    parameter int buf_depth = nabp_pkg::default_buf_depth,
    localparam int s_w = $clog2(line_size),
    localparam int sg_addr_w = $clog2(nabp_pkg::half_turn * line_size)
)
(
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              reg_wr,
    input  logic                              reg_rd,
    input  logic [nabp_pkg::reg_addr_w-1:0]   reg_addr,
    input  logic [nabp_pkg::reg_data_w-1:0]   reg_wdata,
    output logic [nabp_pkg::reg_data_w-1:0]   reg_rdata,
    input  logic                              sg_wr_en,
    input  logic [sg_addr_w-1:0]              sg_wr_addr,
    input  logic [sample_w-1:0]               sg_wr_data,
    output logic                              out_valid,
    output logic [sample_w-1:0]               out_sample,
    output logic [nabp_pkg::angle_w-1:0]      out_angle,
    output logic [s_w-1:0]                    out_s,
    input  logic                              out_pop
);

    logic                          kick;
    logic [nabp_pkg::angle_w-1:0]  angle_step;
    logic                          done;
    logic                          line_done;
    logic                          next_angle;
    logic [s_w-1:0]                s_val;
    logic [nabp_pkg::angle_w-1:0]  angle;
    logic                          has_next_angle;
    logic [sg_addr_w-1:0]          sg_addr;
    logic                          rd_en;
    logic [sample_w-1:0]           rd_data;
    logic                          push;
    logic [nabp_pkg::angle_w-1:0]  push_angle;
    logic [s_w-1:0]                push_s;
    logic                          credit_return;

    nabp_config_regs config_regs_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .kick       (kick),
        .angle_step (angle_step),
        .done       (done),
        .line_done  (line_done)
    );

    sinogram_addresser #(.line_size(line_size)) addresser_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .kick           (kick),
        .angle_step     (angle_step),
        .s_val          (s_val),
        .next_angle     (next_angle),
        .angle          (angle),
        .has_next_angle (has_next_angle),
        .done           (done),
        .sg_addr        (sg_addr)
    );

    sinogram_ram #(.line_size(line_size), .sample_w(sample_w)) ram_i (
        .clk     (clk),
        .wr_en   (sg_wr_en),
        .wr_addr (sg_wr_addr),
        .wr_data (sg_wr_data),
        .rd_en   (rd_en),
        .rd_addr (sg_addr),
        .rd_data (rd_data)
    );

    projection_line_fetcher #(.line_size(line_size), .buf_depth(buf_depth)) fetcher_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .kick           (kick),
        .next_angle     (next_angle),
        .s_val          (s_val),
        .angle          (angle),
        .has_next_angle (has_next_angle),
        .done           (done),
        .rd_en          (rd_en),
        .push           (push),
        .push_angle     (push_angle),
        .push_s         (push_s),
        .credit_return  (credit_return),
        .line_done      (line_done)
    );

    // read data and its tag arrive together
    line_buffer #(
        .line_size (line_size),
        .sample_w  (sample_w),
        .buf_depth (buf_depth)
    ) line_buffer_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .push          (push),
        .push_sample   (rd_data),
        .push_angle    (push_angle),
        .push_s        (push_s),
        .out_pop       (out_pop),
        .out_valid     (out_valid),
        .out_sample    (out_sample),
        .out_angle     (out_angle),
        .out_s         (out_s),
        .credit_return (credit_return)
    );

endmodule

//--- line_buffer.sv
module line_buffer
#(
    parameter int line_size = nabp_pkg::default_line_size,
    parameter int sample_w = nabp_pkg::default_sample_w,
    parameter int buf_depth = nabp_pkg::default_buf_depth,
    localparam int s_w = $clog2(line_size),
    localparam int ptr_w = (buf_depth > 1) ? $clog2(buf_depth) : 1,
    localparam int cnt_w = $clog2(buf_depth + 1),
    localparam int entry_w = sample_w + nabp_pkg::angle_w + s_w
)
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          push,
    input  logic [sample_w-1:0]           push_sample,
    input  logic [nabp_pkg::angle_w-1:0]  push_angle,
    input  logic [s_w-1:0]                push_s,
    input  logic                          out_pop,
    output logic                          out_valid,
    output logic [sample_w-1:0]           out_sample,
    output logic [nabp_pkg::angle_w-1:0]  out_angle,
    output logic [s_w-1:0]                out_s,
    output logic                          credit_return
);

    logic [entry_w-1:0] mem [buf_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               pop;

    assign pop = out_pop && out_valid;
    assign out_valid = (count != '0);

    // head entry is always on the outputs
    assign {out_sample, out_angle, out_s} = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= {push_sample, push_angle, push_s};
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == ptr_w'(buf_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == ptr_w'(buf_depth - 1)) ? '0 : rd_ptr + 1'b1;
            // credits keep push off a full buffer
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            credit_return <= pop;
        end
    end

endmodule

//--- projection_line_fetcher.sv
module projection_line_fetcher
#(
    parameter int line_size = nabp_pkg::default_line_size,
    parameter int buf_depth = nabp_pkg::default_buf_depth,
    localparam int s_w = $clog2(line_size),
    localparam int credit_w = $clog2(buf_depth + 1)
)
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          kick,
    output logic                          next_angle,
    output logic [s_w-1:0]                s_val,
    input  logic [nabp_pkg::angle_w-1:0]  angle,
    input  logic                          has_next_angle,
    input  logic                          done,
    output logic                          rd_en,
    output logic                          push,
    output logic [nabp_pkg::angle_w-1:0]  push_angle,
    output logic [s_w-1:0]                push_s,
    input  logic                          credit_return,
    output logic                          line_done
);

    typedef enum logic [1:0] {idle_s, arm_s, fetch_s, req_s} state_t;

    state_t              state;
    logic [credit_w-1:0] credits;
    logic                last_s;

    // arm_s makes the first request, req_s the one after each line
    assign next_angle = (state == arm_s) || (state == req_s);
    assign line_done = (state == req_s);

    // no credit, no read
    assign rd_en = (state == fetch_s) && (credits != '0);
    assign last_s = (s_val == s_w'(line_size - 1));

    always_ff @(posedge clk)
    begin
        if (reset_n)
            state <= idle_s;
        else
        begin
            case (state)
                idle_s:
                    if (kick)
                        state <= arm_s;
                arm_s:
                    state <= fetch_s;
                fetch_s:
                    if (rd_en && last_s)
                        state <= req_s;
                req_s:
                    if (done)
                        state <= idle_s;
                    else if (has_next_angle)
                        state <= fetch_s;
                default:
                    state <= idle_s;
            endcase
        end
    end

    // position wraps to 0 after the last sample, line_size is a power of two
    always_ff @(posedge clk)
    begin
        if (reset_n || kick)
            s_val <= '0;
        else if (rd_en)
            s_val <= s_val + 1'b1;
    end

    // spent at issue, returned per pop
    always_ff @(posedge clk)
    begin
        if (reset_n)
            credits <= credit_w'(buf_depth);
        else
        begin
            case ({rd_en, credit_return})
                2'b10:
                    credits <= credits - 1'b1;
                2'b01:
                    credits <= credits + 1'b1;
                default:
                    credits <= credits;
            endcase
        end
    end

    // push lines up with the RAM read data
    always_ff @(posedge clk)
    begin
        if (reset_n)
            push <= 1'b0;
        else
            push <= rd_en;
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            push_angle <= angle;
            push_s <= s_val;
        end
    end

endmodule

//--- sinogram_ram.sv
module sinogram_ram
#(
    parameter int line_size = nabp_pkg::default_line_size,
    parameter int sample_w = nabp_pkg::default_sample_w,
    localparam int depth = nabp_pkg::half_turn * line_size,
    localparam int addr_w = $clog2(depth)
)
(
    input  logic                clk,
    input  logic                wr_en,
    input  logic [addr_w-1:0]   wr_addr,
    input  logic [sample_w-1:0] wr_data,
    input  logic                rd_en,
    input  logic [addr_w-1:0]   rd_addr,
    output logic [sample_w-1:0] rd_data
);

    // one line per angle, angle index major
    logic [sample_w-1:0] mem [depth];

    // host load port
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

//--- sinogram_addresser.sv
module sinogram_addresser
#(
    parameter int line_size = nabp_pkg::default_line_size,
    localparam int s_w = $clog2(line_size),
    localparam int sg_addr_w = $clog2(nabp_pkg::half_turn * line_size)
)
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          kick,
    input  logic [nabp_pkg::angle_w-1:0]  angle_step,
    input  logic [s_w-1:0]                s_val,
    input  logic                          next_angle,
    output logic [nabp_pkg::angle_w-1:0]  angle,
    output logic                          has_next_angle,
    output logic                          done,
    output logic [sg_addr_w-1:0]          sg_addr
);

    localparam int aw = nabp_pkg::angle_w;

    typedef enum logic {ready_s, work_s} state_t;

    state_t               state;
    logic                 initialised;
    logic [sg_addr_w-1:0] base_addr;
    logic [aw:0]          angle_sum;

    // one extra bit so that angle plus step cannot wrap
    assign angle_sum = {1'b0, angle} + {1'b0, angle_step};
    assign has_next_angle = (angle_sum < nabp_pkg::half_turn);

    // request with nothing left ends the run
    assign done = (state == work_s) && next_angle && !has_next_angle;

    assign sg_addr = base_addr + {{(sg_addr_w-s_w){1'b0}}, s_val};

    always_ff @(posedge clk)
    begin
        if (reset_n)
            state <= ready_s;
        else if ((state == ready_s) && kick)
            state <= work_s;
        else if (done)
            state <= ready_s;
    end

    always_ff @(posedge clk)
    begin
        if (reset_n || (state == ready_s))
        begin
            initialised <= 1'b0;
            angle <= '0;
            base_addr <= '0;
        end
        else if (next_angle && has_next_angle)
        begin
            // first request only arms, angle 0 is already in place
            if (!initialised)
                initialised <= 1'b1;
            else
            begin
                angle <= angle + angle_step;
                base_addr <= base_addr + sg_addr_w'(line_size);
            end
        end
    end

endmodule

//--- nabp_config_regs.sv
module nabp_config_regs
(
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              reg_wr,
    input  logic                              reg_rd,
    input  logic [nabp_pkg::reg_addr_w-1:0]   reg_addr,
    input  logic [nabp_pkg::reg_data_w-1:0]   reg_wdata,
    output logic [nabp_pkg::reg_data_w-1:0]   reg_rdata,
    output logic                              kick,
    output logic [nabp_pkg::angle_w-1:0]      angle_step,
    input  logic                              done,
    input  logic                              line_done
);

    localparam int data_w = nabp_pkg::reg_data_w;
    localparam int aw = nabp_pkg::angle_w;

    logic          busy;
    logic          done_flag;
    logic [aw-1:0] angle_count;

    // bus writes and the one-cycle kick
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            kick <= 1'b0;
            angle_step <= aw'(1);
        end
        else
        begin
            kick <= reg_wr && (reg_addr == nabp_pkg::reg_ctrl) && reg_wdata[0];
            if (reg_wr && (reg_addr == nabp_pkg::reg_step))
                angle_step <= reg_wdata[aw-1:0];
        end
    end

    // run status, cleared by each kick
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            busy <= 1'b0;
            done_flag <= 1'b0;
            angle_count <= '0;
        end
        else if (kick)
        begin
            busy <= 1'b1;
            done_flag <= 1'b0;
            angle_count <= '0;
        end
        else
        begin
            if (done)
            begin
                busy <= 1'b0;
                done_flag <= 1'b1;
            end
            // one pulse per completed line
            if (line_done)
                angle_count <= angle_count + 1'b1;
        end
    end

    // read data lands one cycle after reg_rd
    always_ff @(posedge clk)
    begin
        if (reg_rd)
        begin
            case (reg_addr)
                nabp_pkg::reg_ctrl:
                    reg_rdata <= '0;
                nabp_pkg::reg_step:
                    reg_rdata <= {{(data_w-aw){1'b0}}, angle_step};
                nabp_pkg::reg_status:
                    reg_rdata <= {{(data_w-2){1'b0}}, done_flag, busy};
                default:
                    reg_rdata <= {{(data_w-aw){1'b0}}, angle_count};
            endcase
        end
    end

endmodule

//--- nabp_pkg.sv
package nabp_pkg;

    // angle in whole degrees, 0 to 179
    localparam int angle_w = 8;

    // exclusive upper bound of the angle sweep
    localparam int half_turn = 180;

    // host register bus
    localparam int reg_addr_w = 2;
    localparam int reg_data_w = 16;

    // register map
    localparam logic [reg_addr_w-1:0] reg_ctrl = 2'd0;
    localparam logic [reg_addr_w-1:0] reg_step = 2'd1;
    localparam logic [reg_addr_w-1:0] reg_status = 2'd2;
    localparam logic [reg_addr_w-1:0] reg_count = 2'd3;

    // top level defaults
    localparam int default_line_size = 16;
    localparam int default_sample_w = 16;
    localparam int default_buf_depth = 8;

endpackage
